//--- src/ddr4_bus_pkg.sv
package ddr4_bus_pkg;

    // ========================================================================
    // Command/address bus widths
    // ========================================================================

    // Row/column address A16..A0 with the command field on A16..A14
    parameter int ADDR_WIDTH = 17;
    parameter int BA_WIDTH   = 2;
    parameter int BG_WIDTH   = 2;

    // Second rank is the one that may be mirrored
    parameter int NUM_RANKS  = 2;

    // ========================================================================
    // Bus and per-rank views
    // ========================================================================

    // Raw bus as sampled on the clock edge (24 bits)
    typedef struct packed {
        logic [NUM_RANKS-1:0]  cs_n;
        logic                  act_n;
        logic [ADDR_WIDTH-1:0] adr;
        logic [BA_WIDTH-1:0]   ba;
        logic [BG_WIDTH-1:0]   bg;
    } ca_bus_t;

    // What one rank's devices see after mirroring and masking (21 bits)
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] adr;
        logic [BA_WIDTH-1:0]   ba;
        logic [BG_WIDTH-1:0]   bg;
    } rank_ca_t;

endpackage

//--- src/ddr4_cmd_pkg.sv
package ddr4_cmd_pkg;

    // ========================================================================
    // Opcodes on A16..A14 (RAS_n, CAS_n, WE_n) with ACT_n high
    // ========================================================================

    parameter logic [2:0] OPC_MRS = 3'b000;
    parameter logic [2:0] OPC_REF = 3'b001;
    parameter logic [2:0] OPC_PRE = 3'b010;
    // Only valid with ACT_n low
    parameter logic [2:0] OPC_ACT = 3'b011;
    parameter logic [2:0] OPC_WR  = 3'b100;
    parameter logic [2:0] OPC_RD  = 3'b101;
    parameter logic [2:0] OPC_ZQC = 3'b110;
    parameter logic [2:0] OPC_NOP = 3'b111;

    // ========================================================================
    // Decoded command
    // ========================================================================

    typedef enum logic [3:0] {
        DSEL    = 4'd0,
        MRS     = 4'd1,
        REF     = 4'd2,
        PRE     = 4'd3,
        ACT     = 4'd4,
        WR      = 4'd5,
        RD      = 4'd6,
        ZQC     = 4'd7,
        NOP     = 4'd8,
        ILLEGAL = 4'd9
    } cmd_e;

    // Column commands drop A13..A11 (A12 BC_n, A11 and A13 unused here)
    parameter logic [ddr4_bus_pkg::ADDR_WIDTH-1:0] COL_ADR_MASK = 17'h1C7FF;

endpackage

//--- src/cmd_decoder.sv
`timescale 1ns/100ps

module cmd_decoder (
    input  ddr4_bus_pkg::ca_bus_t ca_in,
    output ddr4_cmd_pkg::cmd_e    cmd
);

    // Command field rides on the top three address bits
    logic [2:0] opc;

    assign opc = ca_in.adr[ddr4_bus_pkg::ADDR_WIDTH-1 -: 3];

    // Priority: deselect, then activate, then the opcode table
    always_comb begin
        if (&ca_in.cs_n) begin
            cmd = ddr4_cmd_pkg::DSEL;
        end else if (!ca_in.act_n) begin
            cmd = ddr4_cmd_pkg::ACT;
        end else begin
            case (opc)
                ddr4_cmd_pkg::OPC_MRS: cmd = ddr4_cmd_pkg::MRS;
                ddr4_cmd_pkg::OPC_REF: cmd = ddr4_cmd_pkg::REF;
                ddr4_cmd_pkg::OPC_PRE: cmd = ddr4_cmd_pkg::PRE;
                ddr4_cmd_pkg::OPC_WR:  cmd = ddr4_cmd_pkg::WR;
                ddr4_cmd_pkg::OPC_RD:  cmd = ddr4_cmd_pkg::RD;
                ddr4_cmd_pkg::OPC_ZQC: cmd = ddr4_cmd_pkg::ZQC;
                ddr4_cmd_pkg::OPC_NOP: cmd = ddr4_cmd_pkg::NOP;
                // ACT code with ACT_n high has no meaning
                ddr4_cmd_pkg::OPC_ACT: cmd = ddr4_cmd_pkg::ILLEGAL;
                default:               cmd = ddr4_cmd_pkg::ILLEGAL;
            endcase
        end
    end

endmodule

//--- src/ca_rank_mapper.sv
`timescale 1ns/100ps

module ca_rank_mapper #(
    parameter bit MIRROR_EN = 1'b0
) (
    input  ddr4_bus_pkg::ca_bus_t                             ca_in,
    input  ddr4_cmd_pkg::cmd_e                                cmd,
    output ddr4_bus_pkg::rank_ca_t [ddr4_bus_pkg::NUM_RANKS-1:0] rank_ca
);

    // ========================================================================
    // Rank 1 mirroring
    // ========================================================================

    logic [ddr4_bus_pkg::ADDR_WIDTH-1:0] mir_adr;
    logic [ddr4_bus_pkg::BA_WIDTH-1:0]   mir_ba;
    logic [ddr4_bus_pkg::BG_WIDTH-1:0]   mir_bg;
    logic                                col_cmd;

    // Odd/even pairs swap on the back side of a mirrored module
    always_comb begin
        mir_adr = ca_in.adr;
        mir_ba  = ca_in.ba;
        mir_bg  = ca_in.bg;
        if (MIRROR_EN) begin
            mir_adr[3]  = ca_in.adr[4];
            mir_adr[4]  = ca_in.adr[3];
            mir_adr[5]  = ca_in.adr[6];
            mir_adr[6]  = ca_in.adr[5];
            mir_adr[7]  = ca_in.adr[8];
            mir_adr[8]  = ca_in.adr[7];
            mir_adr[11] = ca_in.adr[13];
            mir_adr[13] = ca_in.adr[11];
            mir_ba      = {ca_in.ba[0], ca_in.ba[1]};
            mir_bg      = {ca_in.bg[0], ca_in.bg[1]};
        end
    end

    // ========================================================================
    // Column address masking
    // ========================================================================

    // Taken from the decoded command, never from raw opcode bits
    assign col_cmd = (cmd == ddr4_cmd_pkg::WR) || (cmd == ddr4_cmd_pkg::RD);

    always_comb begin
        rank_ca[0].adr = ca_in.adr;
        rank_ca[0].ba  = ca_in.ba;
        rank_ca[0].bg  = ca_in.bg;

        rank_ca[1].adr = mir_adr;
        rank_ca[1].ba  = mir_ba;
        rank_ca[1].bg  = mir_bg;

        // Mask after the swap so both ranks lose the same physical pins
        if (col_cmd) begin
            rank_ca[0].adr = rank_ca[0].adr & ddr4_cmd_pkg::COL_ADR_MASK;
            rank_ca[1].adr = rank_ca[1].adr & ddr4_cmd_pkg::COL_ADR_MASK;
        end
    end

endmodule

//--- src/bus_dir_ctrl.sv
`timescale 1ns/100ps

module bus_dir_ctrl (
    input  logic                                                c0_ddr4_ck_t,
    input  logic                                                rst_n,
    input  ddr4_cmd_pkg::cmd_e                                  cmd,
    input  ddr4_bus_pkg::rank_ca_t [ddr4_bus_pkg::NUM_RANKS-1:0] rank_ca,
    output ddr4_cmd_pkg::cmd_e                                  cmd_q,
    output ddr4_bus_pkg::rank_ca_t [ddr4_bus_pkg::NUM_RANKS-1:0] rank_ca_q,
    output logic                                                wr_en
);

    // ========================================================================
    // Direction state
    // ========================================================================

    logic wr_en_d;

    // Set by a write, cleared by a read, held otherwise
    always_comb begin
        case (cmd)
            ddr4_cmd_pkg::WR: wr_en_d = 1'b1;
            ddr4_cmd_pkg::RD: wr_en_d = 1'b0;
            default:          wr_en_d = wr_en;
        endcase
    end

    always_ff @(posedge c0_ddr4_ck_t or negedge rst_n) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= wr_en_d;
        end
    end

    // ========================================================================
    // Output stage
    // ========================================================================

    // One new sample every cycle, no stall
    always_ff @(posedge c0_ddr4_ck_t or negedge rst_n) begin
        if (!rst_n) begin
            cmd_q     <= ddr4_cmd_pkg::DSEL;
            rank_ca_q <= '0;
        end else begin
            cmd_q     <= cmd;
            rank_ca_q <= rank_ca;
        end
    end

endmodule

//--- src/ddr4_cmd_monitor.sv
`timescale 1ns/100ps

module ddr4_cmd_monitor #(
    parameter bit MIRROR_EN = 1'b1
) (
    input  logic                                                c0_ddr4_ck_t,
    input  logic                                                rst_n,
    input  ddr4_bus_pkg::ca_bus_t                               ca_in,
    output ddr4_cmd_pkg::cmd_e                                  cmd_q,
    output ddr4_bus_pkg::rank_ca_t [ddr4_bus_pkg::NUM_RANKS-1:0] rank_ca_q,
    output logic                                                wr_en
);

    // Combinational decode and rank views, same cycle as the bus
    ddr4_cmd_pkg::cmd_e                                  cmd;
    ddr4_bus_pkg::rank_ca_t [ddr4_bus_pkg::NUM_RANKS-1:0] rank_ca;

    // ========================================================================
    // Decode
    // ========================================================================

    cmd_decoder i_cmd_decoder (
        .ca_in (ca_in),
        .cmd   (cmd)
    );

    // ========================================================================
    // Per-rank address, bank and bank group
    // ========================================================================

    ca_rank_mapper #(
        .MIRROR_EN (MIRROR_EN)
    ) i_ca_rank_mapper (
        .ca_in   (ca_in),
        .cmd     (cmd),
        .rank_ca (rank_ca)
    );

    // ========================================================================
    // Registered outputs and write/read direction
    // ========================================================================

    bus_dir_ctrl i_bus_dir_ctrl (
        .c0_ddr4_ck_t (c0_ddr4_ck_t),
        .rst_n        (rst_n),
        .cmd          (cmd),
        .rank_ca      (rank_ca),
        .cmd_q        (cmd_q),
        .rank_ca_q    (rank_ca_q),
        .wr_en        (wr_en)
    );

endmodule

//--- dv/ddr4_cmd_monitor_chk.sv
`timescale 1ns/100ps

module ddr4_cmd_monitor_chk #(
    parameter bit MIRROR_EN = 1'b1
) (
    input logic                                                 c0_ddr4_ck_t,
    input logic                                                 rst_n,
    input ddr4_bus_pkg::ca_bus_t                                ca_in,
    input ddr4_cmd_pkg::cmd_e                                   cmd,
    input ddr4_cmd_pkg::cmd_e                                   cmd_q,
    input ddr4_bus_pkg::rank_ca_t [ddr4_bus_pkg::NUM_RANKS-1:0] rank_ca_q,
    input logic                                                 wr_en
);

    // Direction flag moves only after a column command
    a_wr_en_source: assert property (@(posedge c0_ddr4_ck_t) disable iff (!rst_n)
        $changed(wr_en) |-> ($past(cmd) == ddr4_cmd_pkg::WR || $past(cmd) == ddr4_cmd_pkg::RD))
        else $error("wr_en changed without a WR or RD in the cycle before");

    // An activate needs ACT_n low on the sampled bus
    a_act_source: assert property (@(posedge c0_ddr4_ck_t) disable iff (!rst_n)
        (cmd_q == ddr4_cmd_pkg::ACT) |-> !$past(ca_in.act_n))
        else $error("cmd_q shows ACT but act_n was high on the bus");

    // A12 is not part of any mirrored pair
    if (MIRROR_EN) begin : g_mirror
        a_a12_same: assert property (@(posedge c0_ddr4_ck_t) disable iff (!rst_n)
            rank_ca_q[0].adr[12] == rank_ca_q[1].adr[12])
            else $error("rank 0 and rank 1 disagree on A12");
    end

endmodule

//--- dv/tb_ddr4_cmd_monitor.sv
`timescale 1ns/100ps

module tb_ddr4_cmd_monitor;

    localparam int NUM_ROWS       = 13;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = NUM_ROWS + RESET_CYCLES + 20;

    // One table row with the bus values to drive and the outputs one cycle later
    typedef struct packed {
        logic [1:0]         cs_n;
        logic               act_n;
        logic [16:0]        adr;
        logic [1:0]         ba;
        logic [1:0]         bg;
        ddr4_cmd_pkg::cmd_e exp_cmd;
        logic [16:0]        r0_adr;
        logic [1:0]         r0_ba;
        logic [1:0]         r0_bg;
        logic [16:0]        r1_adr;
        logic [1:0]         r1_ba;
        logic [1:0]         r1_bg;
        logic               exp_wr;
    } row_t;

    logic                                                 c0_ddr4_ck_t;
    logic                                                 rst_n;
    ddr4_bus_pkg::ca_bus_t                                ca_in;
    ddr4_cmd_pkg::cmd_e                                   cmd_q;
    ddr4_bus_pkg::rank_ca_t [ddr4_bus_pkg::NUM_RANKS-1:0] rank_ca_q;
    logic                                                 wr_en;

    row_t rows [NUM_ROWS];
    int   cycle_count;

    // ========================================================================
    // DUT, checker and clock
    // ========================================================================

    ddr4_cmd_monitor #(
        .MIRROR_EN (1'b1)
    ) i_ddr4_cmd_monitor (
        .c0_ddr4_ck_t (c0_ddr4_ck_t),
        .rst_n        (rst_n),
        .ca_in        (ca_in),
        .cmd_q        (cmd_q),
        .rank_ca_q    (rank_ca_q),
        .wr_en        (wr_en)
    );

    bind ddr4_cmd_monitor ddr4_cmd_monitor_chk #(
        .MIRROR_EN (MIRROR_EN)
    ) i_ddr4_cmd_monitor_chk (
        .c0_ddr4_ck_t (c0_ddr4_ck_t),
        .rst_n        (rst_n),
        .ca_in        (ca_in),
        .cmd          (cmd),
        .cmd_q        (cmd_q),
        .rank_ca_q    (rank_ca_q),
        .wr_en        (wr_en)
    );

    always #20 c0_ddr4_ck_t = ~c0_ddr4_ck_t;

    always @(posedge c0_ddr4_ck_t) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // ========================================================================
    // Helpers
    // ========================================================================

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Expected views for MIRROR_EN = 1
    task automatic fill_table();
        // DSEL wins over act_n low and a WR opcode
        rows[0]  = '{2'b11, 1'b0, 17'h10000, 2'b00, 2'b00, ddr4_cmd_pkg::DSEL,
                     17'h10000, 2'b00, 2'b00, 17'h10000, 2'b00, 2'b00, 1'b0};
        // ACT wins over the opcode and keeps A13..A11
        rows[1]  = '{2'b10, 1'b0, 17'h13800, 2'b00, 2'b00, ddr4_cmd_pkg::ACT,
                     17'h13800, 2'b00, 2'b00, 17'h13800, 2'b00, 2'b00, 1'b0};
        rows[2]  = '{2'b01, 1'b1, 17'h0C000, 2'b00, 2'b00, ddr4_cmd_pkg::ILLEGAL,
                     17'h0C000, 2'b00, 2'b00, 17'h0C000, 2'b00, 2'b00, 1'b0};
        // Mirroring with the odd pins set on the bus
        rows[3]  = '{2'b10, 1'b1, 17'h018A9, 2'b01, 2'b10, ddr4_cmd_pkg::MRS,
                     17'h018A9, 2'b01, 2'b10, 17'h03151, 2'b10, 2'b01, 1'b0};
        // Mirroring with the even pins set on the bus
        rows[4]  = '{2'b10, 1'b1, 17'h02350, 2'b10, 2'b01, ddr4_cmd_pkg::MRS,
                     17'h02350, 2'b10, 2'b01, 17'h00AA8, 2'b01, 2'b10, 1'b0};
        rows[5]  = '{2'b10, 1'b1, 17'h18400, 2'b11, 2'b11, ddr4_cmd_pkg::ZQC,
                     17'h18400, 2'b11, 2'b11, 17'h18400, 2'b11, 2'b11, 1'b0};
        // Direction sequence WR NOP REF RD PRE WR
        rows[6]  = '{2'b10, 1'b1, 17'h13808, 2'b01, 2'b00, ddr4_cmd_pkg::WR,
                     17'h10008, 2'b01, 2'b00, 17'h10010, 2'b10, 2'b00, 1'b1};
        rows[7]  = '{2'b10, 1'b1, 17'h1C000, 2'b00, 2'b00, ddr4_cmd_pkg::NOP,
                     17'h1C000, 2'b00, 2'b00, 17'h1C000, 2'b00, 2'b00, 1'b1};
        rows[8]  = '{2'b10, 1'b1, 17'h04000, 2'b00, 2'b00, ddr4_cmd_pkg::REF,
                     17'h04000, 2'b00, 2'b00, 17'h04000, 2'b00, 2'b00, 1'b1};
        rows[9]  = '{2'b01, 1'b1, 17'h17820, 2'b00, 2'b01, ddr4_cmd_pkg::RD,
                     17'h14020, 2'b00, 2'b01, 17'h14040, 2'b00, 2'b10, 1'b0};
        rows[10] = '{2'b10, 1'b1, 17'h08400, 2'b00, 2'b00, ddr4_cmd_pkg::PRE,
                     17'h08400, 2'b00, 2'b00, 17'h08400, 2'b00, 2'b00, 1'b0};
        rows[11] = '{2'b10, 1'b1, 17'h12000, 2'b00, 2'b00, ddr4_cmd_pkg::WR,
                     17'h10000, 2'b00, 2'b00, 17'h10000, 2'b00, 2'b00, 1'b1};
        // Deselected RD opcode leaves the address unmasked and the flag held
        rows[12] = '{2'b11, 1'b1, 17'h14000, 2'b00, 2'b00, ddr4_cmd_pkg::DSEL,
                     17'h14000, 2'b00, 2'b00, 17'h14000, 2'b00, 2'b00, 1'b1};
    endtask

    task automatic drive_row(input row_t r);
        ca_in.cs_n  = r.cs_n;
        ca_in.act_n = r.act_n;
        ca_in.adr   = r.adr;
        ca_in.ba    = r.ba;
        ca_in.bg    = r.bg;
    endtask

    task automatic check_row(input int idx);
        row_t r;
        r = rows[idx];
        check_value(64'(cmd_q), 64'(r.exp_cmd), $sformatf("row %0d cmd_q", idx));
        check_value(64'(rank_ca_q[0].adr), 64'(r.r0_adr), $sformatf("row %0d rank 0 adr", idx));
        check_value(64'(rank_ca_q[0].ba), 64'(r.r0_ba), $sformatf("row %0d rank 0 ba", idx));
        check_value(64'(rank_ca_q[0].bg), 64'(r.r0_bg), $sformatf("row %0d rank 0 bg", idx));
        check_value(64'(rank_ca_q[1].adr), 64'(r.r1_adr), $sformatf("row %0d rank 1 adr", idx));
        check_value(64'(rank_ca_q[1].ba), 64'(r.r1_ba), $sformatf("row %0d rank 1 ba", idx));
        check_value(64'(rank_ca_q[1].bg), 64'(r.r1_bg), $sformatf("row %0d rank 1 bg", idx));
        check_value(64'(wr_en), 64'(r.exp_wr), $sformatf("row %0d wr_en", idx));
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        cycle_count  = 0;
        c0_ddr4_ck_t = 1'b0;
        rst_n        = 1'b0;
        ca_in        = '{cs_n: 2'b11, act_n: 1'b1, adr: '0, ba: '0, bg: '0};
        fill_table();

        repeat (RESET_CYCLES) @(posedge c0_ddr4_ck_t);
        #2;
        rst_n = 1'b1;

        check_value(64'(cmd_q), 64'(ddr4_cmd_pkg::DSEL), "reset cmd_q");
        check_value(64'(rank_ca_q), 64'd0, "reset rank_ca_q");
        check_value(64'(wr_en), 64'd0, "reset wr_en");

        // Check the previous row's outputs, then drive the next row
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge c0_ddr4_ck_t);
            #2;
            if (i > 0) begin
                check_row(i - 1);
            end
            drive_row(rows[i]);
        end
        @(posedge c0_ddr4_ck_t);
        #2;
        check_row(NUM_ROWS - 1);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- sources.f
src/ddr4_bus_pkg.sv
src/ddr4_cmd_pkg.sv
src/cmd_decoder.sv
src/ca_rank_mapper.sv
src/bus_dir_ctrl.sv
src/ddr4_cmd_monitor.sv
dv/ddr4_cmd_monitor_chk.sv
dv/tb_ddr4_cmd_monitor.sv

//--- Makefile
TOP := tb_ddr4_cmd_monitor
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f sources.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
